// File: run_sim.sh
#!/bin/sh
# compile the uart_rx testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_uart_rx -f uart_rx.f --Mdir obj_dir -o tb_uart_rx

./obj_dir/tb_uart_rx > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log
then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0

// File: tests/tb_uart_rx.sv
`timescale 1ns/1ps
`include "uart_rx_consts.svh"

module tb_uart_rx;

  import uart_rx_pkg::*;

  localparam int MAX_TESTS  = 64;
  localparam int FIELDS     = 12;   // values per vector line
  localparam int WAIT_CLKS  = 200;  // receive_full must show up within this
  localparam int GLITCH_BIT = 3;    // data bit that gets the glitch
  localparam int GLITCH_AT  = 7;    // ticks into that bit

  logic     clk;
  logic     aresetn;
  logic     baud_tick = 1'b0;
  logic     rx;
  logic     bit8;
  logic     parity_en;
  logic     odd_n_even;
  logic     read_rx_byte;
  logic     clear_parity;
  logic     clear_framing_error;
  rx_byte_t rx_byte;
  logic     receive_full;
  logic     overflow;
  logic     parity_err;
  logic     framing_error;

  logic [7:0] vec_mem [0:MAX_TESTS*FIELDS-1];
  int         num_tests;
  int         errors;
  int         test_errors;
  int         failed_tests;
  int         seed;
  int         tick_div    = 0;
  int         cycles      = 0;
  int         cycle_limit = 0;

  uart_rx i_dut (
    .clk                 (clk),
    .aresetn             (aresetn),
    .baud_tick           (baud_tick),
    .rx                  (rx),
    .bit8                (bit8),
    .parity_en           (parity_en),
    .odd_n_even          (odd_n_even),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

  // ---------------------------------------------------------------------------
  // clock, baud strobe and watchdog
  // ---------------------------------------------------------------------------
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk)
  begin
    baud_tick <= (tick_div == 3);  // one clock in four
    tick_div  <= (tick_div == 3) ? 0 : tick_div + 1;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if ((cycle_limit > 0) && (cycles > cycle_limit))
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------
  // returns on the falling edge right after the n-th tick
  task automatic wait_ticks(input int n);
    int k;
    k = 0;
    while (k < n)
    begin
      @(posedge clk);
      if (baud_tick)
        k++;
    end
    @(negedge clk);
  endtask

  // start bit, lsb first data, optional parity, stop bit
  task automatic send_frame(input logic [7:0] data, input logic bad_par,
                            input logic bad_stop, input logic glitch);
    logic [`UART_WORD_W-1:0] bits;
    logic [7:0]              sent;
    logic                    par;
    int                      nbits;
    int                      k;
    sent  = bit8 ? data : {1'b0, data[6:0]};
    par   = odd_n_even ^ (^sent) ^ bad_par;  // even: total ones even
    bits  = bit8 ? {par, sent} : {1'b0, par, sent[6:0]};
    nbits = 7;
    if (bit8)
      nbits++;
    if (parity_en)
      nbits++;
    rx = 1'b0;
    wait_ticks(`UART_OVERSAMPLE);
    for (k = 0; k < nbits; k++)
    begin
      rx = bits[0];
      if (glitch && (k == GLITCH_BIT))
      begin
        wait_ticks(GLITCH_AT);
        rx = ~bits[0];  // seen by exactly one tick
        wait_ticks(1);
        rx = bits[0];
        wait_ticks(`UART_OVERSAMPLE - GLITCH_AT - 1);
      end
      else
      begin
        wait_ticks(`UART_OVERSAMPLE);
      end
      bits = bits >> 1;
    end
    rx = ~bad_stop;
    wait_ticks(`UART_OVERSAMPLE);
    rx = 1'b1;
  endtask

  task automatic wait_full();
    int n;
    n = 0;
    while (!receive_full && (n < WAIT_CLKS))
    begin
      @(negedge clk);
      n++;
    end
    if (!receive_full)
    begin
      $display("%0t: receive_full did not rise after the frame", $time);
      test_errors++;
    end
  endtask

  task automatic read_byte();
    read_rx_byte = 1'b1;
    @(negedge clk);
    read_rx_byte = 1'b0;
  endtask

  task automatic clear_parity_flag();
    clear_parity = 1'b1;
    @(negedge clk);
    clear_parity = 1'b0;
  endtask

  task automatic clear_framing_flag();
    clear_framing_error = 1'b1;
    @(negedge clk);
    clear_framing_error = 1'b0;
  endtask

  task automatic compare_byte(input string name, input rx_byte_t expected,
                              input rx_byte_t actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  // ---------------------------------------------------------------------------
  // one vector line
  // ---------------------------------------------------------------------------
  task automatic run_test(input int t);
    int       b;
    int       gap;
    rx_byte_t exp_byte;
    logic     exp_par;
    logic     exp_frm;
    logic     exp_ovf;
    logic     skip_read;
    b           = t * FIELDS;
    exp_byte    = vec_mem[b+8];
    exp_par     = vec_mem[b+9][0];
    exp_frm     = vec_mem[b+10][0];
    exp_ovf     = vec_mem[b+11][0];
    skip_read   = vec_mem[b+7][0];
    test_errors = 0;
    bit8        = vec_mem[b][0];  // config only changes while the line idles
    parity_en   = vec_mem[b+1][0];
    odd_n_even  = vec_mem[b+2][0];
    gap = 4 + int'($unsigned($random(seed)) % 8);
    wait_ticks(gap);
    send_frame(vec_mem[b+3], vec_mem[b+4][0], vec_mem[b+5][0], vec_mem[b+6][0]);
    wait_full();
    compare_byte("rx_byte", exp_byte, rx_byte);
    compare_flag("parity_err", exp_par, parity_err);
    compare_flag("framing_error", exp_frm, framing_error);
    compare_flag("overflow", exp_ovf, overflow);
    if (!skip_read)
    begin
      read_byte();
      compare_flag("receive_full", 1'b0, receive_full);
      compare_flag("overflow", 1'b0, overflow);
    end
    if (exp_par)
    begin
      compare_flag("parity_err", 1'b1, parity_err);  // must survive the read
      clear_parity_flag();
      compare_flag("parity_err", 1'b0, parity_err);
    end
    if (exp_frm)
    begin
      compare_flag("framing_error", 1'b1, framing_error);
      clear_framing_flag();
      compare_flag("framing_error", 1'b0, framing_error);
    end
    errors += test_errors;
    if (test_errors == 0)
    begin
      $display("test %0d: data %h byte %h passed", t, vec_mem[b+3], rx_byte);
    end
    else
    begin
      $display("test %0d: data %h failed with %0d errors", t, vec_mem[b+3], test_errors);
      failed_tests++;
    end
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------
  initial
  begin
    int i;
    aresetn             = 1'b0;
    rx                  = 1'b1;  // idle line
    bit8                = 1'b1;
    parity_en           = 1'b0;
    odd_n_even          = 1'b0;
    read_rx_byte        = 1'b0;
    clear_parity        = 1'b0;
    clear_framing_error = 1'b0;
    seed                = 32'h5e;
    errors              = 0;
    failed_tests        = 0;
    num_tests           = 0;
    for (i = 0; i < MAX_TESTS * FIELDS; i++)
      vec_mem[i] = 8'hff;  // marks the end of the file
    $readmemh("tests/uart_rx_vectors.txt", vec_mem);
    while ((num_tests < MAX_TESTS) && (vec_mem[num_tests*FIELDS] != 8'hff))
      num_tests++;
    if (num_tests == 0)
    begin
      $display("no test vectors were read from tests/uart_rx_vectors.txt");
      errors++;
    end
    cycle_limit = num_tests * (12 * `UART_OVERSAMPLE * 4 + 64) + 1000;

    repeat (16) @(posedge clk);
    @(negedge clk);
    aresetn = 1'b1;

    test_errors = 0;
    compare_byte("rx_byte", 8'h00, rx_byte);
    compare_flag("receive_full", 1'b0, receive_full);
    compare_flag("overflow", 1'b0, overflow);
    compare_flag("parity_err", 1'b0, parity_err);
    compare_flag("framing_error", 1'b0, framing_error);
    errors += test_errors;

    for (i = 0; i < num_tests; i++)
      run_test(i);

    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             num_tests, num_tests - failed_tests, failed_tests, errors);
    if (errors == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: tests/uart_rx_vectors.txt
// bit8 parity_en odd_n_even data | bad_parity low_stop glitch skip_read
// expected: rx_byte parity_err framing_error overflow (all hex)
1 0 0 a5  0 0 0 0  a5 0 0 0
1 0 0 3c  0 0 0 0  3c 0 0 0
1 0 0 00  0 0 0 0  00 0 0 0
1 0 0 ff  0 0 0 0  ff 0 0 0
0 0 0 d5  0 0 0 0  55 0 0 0
0 1 0 4b  0 0 0 0  4b 0 0 0
0 1 1 4b  0 0 0 0  4b 0 0 0
0 1 1 c4  0 0 0 0  44 0 0 0
1 1 0 96  0 0 0 0  96 0 0 0
1 1 1 96  0 0 0 0  96 0 0 0
1 1 0 e7  1 0 0 0  e7 1 0 0
0 1 1 2a  1 0 0 0  2a 1 0 0
1 0 0 81  0 1 0 0  81 0 1 0
1 1 1 5a  0 1 0 0  5a 0 1 0
1 0 0 11  0 0 0 1  11 0 0 0
1 0 0 22  0 0 0 0  11 0 0 1
1 0 0 33  0 0 0 0  33 0 0 0
0 1 0 6e  0 0 0 1  6e 0 0 0
0 1 0 21  1 0 0 0  6e 1 0 1
1 0 0 a5  0 0 1 0  a5 0 0 0
1 1 0 c3  0 0 1 0  c3 0 0 0
0 0 0 7f  0 0 1 0  7f 0 0 0

// File: uart_rx.f
+incdir+verilog
verilog/uart_rx_pkg.sv
verilog/rx_bit_sampler.sv
verilog/rx_deserializer.sv
verilog/rx_parity_check.sv
verilog/rx_status.sv
verilog/uart_rx.sv
tests/tb_uart_rx.sv

// File: verilog/rx_bit_sampler.sv
`timescale 1ns/1ps
`include "uart_rx_consts.svh"

module rx_bit_sampler (
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick,
  input  logic rx,
  input  logic word_done,
  output logic bit_value,
  output logic bit_strobe,
  output logic frame_start,
  output logic stop_bad
);

  import uart_rx_pkg::*;

  localparam int CNT_W = $clog2(`UART_OVERSAMPLE);

  localparam logic [CNT_W-1:0] START_MID    = CNT_W'(`UART_START_MID);
  localparam logic [CNT_W-1:0] SAMPLE_POINT = CNT_W'(`UART_SAMPLE_POINT);
  localparam logic [CNT_W-1:0] STOP_CHECK   = CNT_W'(`UART_STOP_CHECK);
  localparam logic [CNT_W-1:0] WAIT_LIMIT   = CNT_W'(`UART_WAIT_LIMIT);

  logic [2:0]       samples;   // newest sample on top
  logic [CNT_W-1:0] tick_cnt;  // oversample counter
  logic             cnt_clear;
  rx_state_e        state;

  // ---------------------------------------------------------------------------
  // glitch filter
  // ---------------------------------------------------------------------------
  // a pulse one tick wide can never win the vote
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      samples <= 3'b111;  // idle line
    end
    else if (baud_tick)
    begin
      samples <= {rx, samples[2:1]};
    end
  end

  assign bit_value = (samples[0] & samples[1]) |
                     (samples[1] & samples[2]) |
                     (samples[0] & samples[2]);

  // ---------------------------------------------------------------------------
  // oversample counter
  // ---------------------------------------------------------------------------
  // restarts while the line sits high between frames, and once a start bit
  // or the end of the wait window is reached
  assign cnt_clear = ((state == ST_IDLE) && (bit_value || (tick_cnt == START_MID))) ||
                     ((state == ST_WAIT_HIGH) && (bit_value || (tick_cnt == WAIT_LIMIT)));

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      tick_cnt <= '0;
    end
    else if (baud_tick)
    begin
      if (cnt_clear)
      begin
        tick_cnt <= '0;
      end
      else
      begin
        tick_cnt <= tick_cnt + 1'b1;  // wraps once per bit
      end
    end
  end

  // strobes, one clock wide and only on a tick
  assign frame_start = baud_tick && (state == ST_IDLE) && (tick_cnt == START_MID) && !bit_value;
  assign bit_strobe  = baud_tick && (state == ST_DATA_BITS) && (tick_cnt == SAMPLE_POINT);
  assign stop_bad    = baud_tick && (state == ST_STOP_BIT) && (tick_cnt == STOP_CHECK) &&
                       !bit_value;

  // ---------------------------------------------------------------------------
  // frame FSM
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state <= ST_IDLE;
    end
    else if (baud_tick)
    begin
      unique case (state)
        ST_IDLE:
        begin
          if (frame_start)
          begin
            state <= ST_DATA_BITS;
          end
        end
        ST_DATA_BITS:
        begin
          if (word_done)  // deserializer knows the frame length
          begin
            state <= ST_STOP_BIT;
          end
        end
        ST_STOP_BIT:
        begin
          if (tick_cnt == SAMPLE_POINT)
          begin
            state <= ST_WAIT_HIGH;
          end
        end
        ST_WAIT_HIGH:
        begin
          if (bit_value || (tick_cnt == WAIT_LIMIT))
          begin
            state <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: verilog/rx_deserializer.sv
`timescale 1ns/1ps
`include "uart_rx_consts.svh"

module rx_deserializer (
  input  logic                   clk,
  input  logic                   aresetn,
  input  logic                   baud_tick,
  input  logic                   bit_value,
  input  logic                   bit_strobe,
  input  logic                   frame_start,
  input  logic                   bit8,
  input  logic                   parity_en,
  output uart_rx_pkg::rx_word_u  word,
  output logic                   word_done
);

  import uart_rx_pkg::*;

  logic [3:0] bit_cnt;   // bits taken so far in this frame
  logic [3:0] top_idx;   // where a new bit enters
  rx_word_u   word_q;
  rx_word_u   word_next;

  // 7, 8 or 9 bits per frame
  assign top_idx = 4'd6 + {3'b000, bit8} + {3'b000, parity_en};

  // ---------------------------------------------------------------------------
  // shift register
  // ---------------------------------------------------------------------------
  // bits arrive lsb first and enter at top_idx, so after the last one the
  // word is right-aligned for the current length
  always_comb
  begin
    word_next = word_q;
    if (bit_strobe)
    begin
      for (int i = 0; i < `UART_WORD_W - 1; i++)
      begin
        if (i < int'(top_idx))
        begin
          word_next.bits[i] = word_q.bits[i+1];
        end
      end
      word_next.bits[top_idx] = bit_value;
    end
  end

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      word_q <= '0;
    end
    else if (baud_tick)
    begin
      if (frame_start)
      begin
        word_q <= '0;
      end
      else
      begin
        word_q <= word_next;
      end
    end
  end

  // already holds the last bit on the word_done tick
  assign word = word_next;

  // ---------------------------------------------------------------------------
  // bit counter
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      bit_cnt <= '0;
    end
    else if (baud_tick)
    begin
      if (frame_start)
      begin
        bit_cnt <= '0;
      end
      else if (bit_strobe)
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign word_done = bit_strobe && (bit_cnt == top_idx);  // last expected bit

endmodule

// File: verilog/rx_parity_check.sv
`timescale 1ns/1ps

module rx_parity_check (
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick,
  input  logic bit_value,
  input  logic bit_strobe,
  input  logic frame_start,
  input  logic odd_n_even,
  output logic parity_bad
);

  logic par_acc;   // xor of the bits taken so far
  logic par_next;

  // includes the bit being sampled right now, so the result is ready on
  // the tick of the parity bit itself
  assign par_next = par_acc ^ (bit_strobe & bit_value);

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      par_acc <= 1'b0;
    end
    else if (baud_tick)
    begin
      if (frame_start)
      begin
        par_acc <= 1'b0;  // new frame
      end
      else
      begin
        par_acc <= par_next;
      end
    end
  end

  // even: total count of ones must be even, odd: must be odd
  assign parity_bad = par_next ^ odd_n_even;

endmodule

// File: verilog/rx_status.sv
`timescale 1ns/1ps

module rx_status (
  input  logic                  clk,
  input  logic                  aresetn,
  input  uart_rx_pkg::rx_word_u word,
  input  logic                  word_done,
  input  logic                  parity_bad,
  input  logic                  stop_bad,
  input  logic                  bit8,
  input  logic                  parity_en,
  input  logic                  read_rx_byte,
  input  logic                  clear_parity,
  input  logic                  clear_framing_error,
  output uart_rx_pkg::rx_byte_t rx_byte,
  output logic                  receive_full,
  output logic                  overflow,
  output logic                  parity_err,
  output logic                  framing_error
);

  logic load_byte;   // frame done and room for it
  logic lost_byte;   // frame done but the host has not read yet

  assign load_byte = word_done && !receive_full;
  assign lost_byte = word_done && receive_full;

  // ---------------------------------------------------------------------------
  // holding register
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_byte <= '0;
    end
    else if (load_byte)
    begin
      if (bit8)
      begin
        rx_byte <= word.frame8.data;
      end
      else
      begin
        rx_byte <= {1'b0, word.frame7.data};  // 7-bit mode, top bit zero
      end
    end
  end

  // ---------------------------------------------------------------------------
  // flags
  // ---------------------------------------------------------------------------
  // in each flag the clear comes first so that a set in the same clock wins
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      receive_full  <= 1'b0;
      overflow      <= 1'b0;
      parity_err    <= 1'b0;
      framing_error <= 1'b0;
    end
    else
    begin
      if (read_rx_byte)
      begin
        receive_full <= 1'b0;
        overflow     <= 1'b0;
      end
      if (load_byte)
      begin
        receive_full <= 1'b1;  // held until the host reads
      end
      if (lost_byte)
      begin
        overflow <= 1'b1;      // rx_byte keeps the older byte
      end

      if (clear_parity)
      begin
        parity_err <= 1'b0;
      end
      if (word_done && parity_en && parity_bad)
      begin
        parity_err <= 1'b1;
      end

      if (clear_framing_error)
      begin
        framing_error <= 1'b0;
      end
      if (stop_bad)
      begin
        framing_error <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic                  clk,
  input  logic                  aresetn,
  input  logic                  baud_tick,  // 16x oversampling strobe
  input  logic                  rx,
  input  logic                  bit8,
  input  logic                  parity_en,
  input  logic                  odd_n_even,
  input  logic                  read_rx_byte,
  input  logic                  clear_parity,
  input  logic                  clear_framing_error,
  output uart_rx_pkg::rx_byte_t rx_byte,
  output logic                  receive_full,
  output logic                  overflow,
  output logic                  parity_err,
  output logic                  framing_error
);

  import uart_rx_pkg::*;

  logic     bit_value;
  logic     bit_strobe;
  logic     frame_start;
  logic     stop_bad;
  logic     word_done;
  logic     parity_bad;
  rx_word_u word;

  // ---------------------------------------------------------------------------
  // line timing and frame FSM
  // ---------------------------------------------------------------------------
  rx_bit_sampler i_sampler (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx          (rx),
    .word_done   (word_done),
    .bit_value   (bit_value),
    .bit_strobe  (bit_strobe),
    .frame_start (frame_start),
    .stop_bad    (stop_bad)
  );

  // the two below see the same bit stream side by side
  rx_deserializer i_deser (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .bit_value   (bit_value),
    .bit_strobe  (bit_strobe),
    .frame_start (frame_start),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .word        (word),
    .word_done   (word_done)
  );

  rx_parity_check i_parity (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .bit_value   (bit_value),
    .bit_strobe  (bit_strobe),
    .frame_start (frame_start),
    .odd_n_even  (odd_n_even),
    .parity_bad  (parity_bad)
  );

  // ---------------------------------------------------------------------------
  // host side
  // ---------------------------------------------------------------------------
  rx_status i_status (
    .clk                 (clk),
    .aresetn             (aresetn),
    .word                (word),
    .word_done           (word_done),
    .parity_bad          (parity_bad),
    .stop_bad            (stop_bad),
    .bit8                (bit8),
    .parity_en           (parity_en),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .receive_full        (receive_full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

endmodule

// File: verilog/uart_rx_consts.svh
`ifndef UART_RX_CONSTS_SVH
`define UART_RX_CONSTS_SVH

// ---------------------------------------------------------------------------
// receiver timing, in baud_tick units
// ---------------------------------------------------------------------------

// one serial bit spans this many ticks
`define UART_OVERSAMPLE 16

// ticks of low line before the start bit counts as real
`define UART_START_MID 8

// counter value at which a data or parity bit is taken (mid-bit)
`define UART_SAMPLE_POINT 15

// counter value at which the stop level is looked at
`define UART_STOP_CHECK 14

// longest wait for the line to go high again after the stop bit
`define UART_WAIT_LIMIT 6

// ---------------------------------------------------------------------------
// word size
// ---------------------------------------------------------------------------

// up to 8 data bits plus one parity bit
`define UART_WORD_W 9

`endif

// File: verilog/uart_rx_pkg.sv
`include "uart_rx_consts.svh"

package uart_rx_pkg;

  // ---------------------------------------------------------------------------
  // frame state machine
  // ---------------------------------------------------------------------------
  typedef enum logic [1:0]
  {
    ST_IDLE      = 2'd0,  // waiting for a start bit
    ST_DATA_BITS = 2'd1,  // data and parity bits
    ST_STOP_BIT  = 2'd2,
    ST_WAIT_HIGH = 2'd3   // line must come back high
  } rx_state_e;

  // one byte as handed to the host
  typedef logic [7:0] rx_byte_t;

  // ---------------------------------------------------------------------------
  // received word, right-aligned in the shift register
  // ---------------------------------------------------------------------------
  // 8 data bits: parity sits on top of a full byte
  // 7 data bits: parity right above bit 6, top bit never written
  typedef union packed
  {
    logic [`UART_WORD_W-1:0] bits;  // raw shift register view
    struct packed
    {
      logic       parity;
      logic [7:0] data;
    } frame8;
    struct packed
    {
      logic       spare;
      logic       parity;
      logic [6:0] data;
    } frame7;
  } rx_word_u;

endpackage
